/* hdl/infra_pkg.sv */
package infra_pkg;

  // Phase outputs of one clock manager, also the bit index into its phase vector
  typedef enum logic [1:0] {
    PH_0   = 2'd0,
    PH_90  = 2'd1,
    PH_180 = 2'd2,
    PH_270 = 2'd3
  } phase_e;

  // Division counter width, DIVIDE must stay below 2**DIV_W
  localparam int DIV_W = 8;

  localparam int CNT_W = 16;  // Lock, reset and calibration timers

  // Base clock rising edges in one lock window; window is this many periods
  localparam int EDGES_PER_WINDOW = 4;

  // Default division ratios of the two clock managers
  localparam int DEF_SYS_DIVIDE = 8;
  localparam int DEF_AUX_DIVIDE = 12;

endpackage

/* hdl/clk_phase_gen.sv */
`timescale 1ns/1ns

module clk_phase_gen import infra_pkg::*; #(
  parameter int DIVIDE = 8
) (
  input  logic       sys_clk_in,
  input  logic       rst,
  input  logic       enable,
  output logic [3:0] phase,
  output logic       clk2x
);

  localparam int QUARTER = DIVIDE / 4;
  localparam int HALF    = DIVIDE / 2;
  localparam logic [DIV_W-1:0] LAST = DIV_W'(DIVIDE - 1);

  logic [DIV_W-1:0] cnt;  // Position within one base period

  // High for the half period that starts ph quarters after count zero
  function automatic logic phase_high(input logic [DIV_W-1:0] c, input phase_e ph);
    int pos;
    pos = (int'(c) + DIVIDE - int'(ph) * QUARTER) % DIVIDE;
    return pos < HALF;
  endfunction

  // Double rate, high in the first half of each half period
  function automatic logic dbl_high(input logic [DIV_W-1:0] c);
    int pos;
    pos = int'(c) % HALF;
    return pos < QUARTER;
  endfunction

  always_ff @(posedge sys_clk_in) begin
    if (rst) begin
      cnt   <= '0;
      phase <= '0;
      clk2x <= 1'b0;
    end else if (enable) begin
      if (cnt == LAST) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      phase[PH_0]   <= phase_high(cnt, PH_0);
      phase[PH_90]  <= phase_high(cnt, PH_90);
      phase[PH_180] <= phase_high(cnt, PH_180);
      phase[PH_270] <= phase_high(cnt, PH_270);
      clk2x         <= dbl_high(cnt);
    end else begin
      // Reference gone, counter holds and all outputs park low
      phase <= '0;
      clk2x <= 1'b0;
    end
  end

  // Base and inverted phase cover opposite halves of the period
  a_no_overlap_0_180: assert property (
    @(posedge sys_clk_in) disable iff (rst)
    !(phase[PH_0] && phase[PH_180])
  ) else $error("base and 180 degree phase high together");

endmodule

/* hdl/lock_detect.sv */
`timescale 1ns/1ns

module lock_detect import infra_pkg::*; #(
  parameter int DIVIDE       = 8,
  parameter int LOCK_WINDOWS = 3
) (
  input  logic sys_clk_in,
  input  logic rst,
  input  logic base_clk,
  output logic locked
);

  localparam int WINDOW = EDGES_PER_WINDOW * DIVIDE;
  localparam logic [CNT_W-1:0] WIN_LAST  = CNT_W'(WINDOW - 1);
  localparam logic [CNT_W-1:0] GOOD_LAST = CNT_W'(LOCK_WINDOWS - 1);
  localparam logic [DIV_W:0]   EDGES_EXP = (DIV_W + 1)'(EDGES_PER_WINDOW);

  logic             base_q;
  logic             rise;
  logic             win_end;
  logic             window_good;
  logic [CNT_W-1:0] win_cnt;   // Cycle within the current window
  logic [DIV_W-1:0] edge_cnt;  // Rising edges seen so far in the window
  logic [DIV_W:0]   edge_total;
  logic [CNT_W-1:0] good_cnt;  // Consecutive good windows before this one

  assign rise    = base_clk & ~base_q;
  assign win_end = (win_cnt == WIN_LAST);

  // Count includes an edge landing on the last cycle of the window
  assign edge_total  = {1'b0, edge_cnt} + (DIV_W + 1)'(rise);
  assign window_good = (edge_total == EDGES_EXP);

  always_ff @(posedge sys_clk_in) begin
    if (rst) begin
      base_q   <= 1'b0;
      win_cnt  <= '0;
      edge_cnt <= '0;
      good_cnt <= '0;
      locked   <= 1'b0;
    end else begin
      base_q <= base_clk;
      if (win_end) begin
        win_cnt  <= '0;
        edge_cnt <= '0;
        if (window_good) begin
          if (good_cnt == GOOD_LAST) begin
            locked <= 1'b1;  // Enough good windows in a row
          end else begin
            good_cnt <= good_cnt + 1'b1;
          end
        end else begin
          // One bad window drops lock and restarts the run
          good_cnt <= '0;
          locked   <= 1'b0;
        end
      end else begin
        win_cnt <= win_cnt + 1'b1;
        if (rise && (edge_cnt != '1)) begin
          edge_cnt <= edge_cnt + 1'b1;
        end
      end
    end
  end

  a_lock_at_window_end: assert property (
    @(posedge sys_clk_in) disable iff (rst)
    (locked != $past(locked)) |-> $past(win_end)
  ) else $error("lock changed away from a window boundary");

endmodule

/* hdl/clk_mgr.sv */
`timescale 1ns/1ns

module clk_mgr import infra_pkg::*; #(
  parameter int DIVIDE       = 8,
  parameter int LOCK_WINDOWS = 3
) (
  input  logic sys_clk_in,
  input  logic rst,
  input  logic ref_present,
  output logic clk_out,
  output logic clk90,
  output logic clk180,
  output logic clk270,
  output logic clk2x,
  output logic locked
);

  logic [3:0] phase;

  // Quadrature phases need a ratio divisible by 4 that fits the counter
  if ((DIVIDE % 4 != 0) || (DIVIDE < 4) || (DIVIDE >= (1 << DIV_W))) begin : gen_bad_divide
    $error("clk_mgr DIVIDE %0d must be a multiple of 4 below %0d", DIVIDE, 1 << DIV_W);
  end

  clk_phase_gen #(
    .DIVIDE (DIVIDE)
  ) phase_gen (
    .sys_clk_in (sys_clk_in),
    .rst        (rst),
    .enable     (ref_present),
    .phase      (phase),
    .clk2x      (clk2x)
  );

  // Watches the generated clock, so a missing reference reads as lost lock
  lock_detect #(
    .DIVIDE       (DIVIDE),
    .LOCK_WINDOWS (LOCK_WINDOWS)
  ) lock_det (
    .sys_clk_in (sys_clk_in),
    .rst        (rst),
    .base_clk   (phase[PH_0]),
    .locked     (locked)
  );

  assign clk_out = phase[PH_0];
  assign clk90   = phase[PH_90];
  assign clk180  = phase[PH_180];
  assign clk270  = phase[PH_270];

endmodule

/* hdl/reset_sequencer.sv */
`timescale 1ns/1ns

module reset_sequencer import infra_pkg::*; #(
  parameter int RST_HOLD = 16
) (
  input  logic sys_clk_in,
  input  logic rst,
  input  logic locked,
  output logic power_on_rst
);

  localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(RST_HOLD - 1);

  logic [CNT_W-1:0] hold_cnt;  // Locked cycles seen so far
  logic             released;

  always_ff @(posedge sys_clk_in) begin
    if (rst || !locked) begin
      // Any loss of lock restarts the hold
      hold_cnt <= '0;
      released <= 1'b0;
    end else if (!released) begin
      if (hold_cnt == HOLD_LAST) begin
        released <= 1'b1;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  assign power_on_rst = !locked || !released;  // Drops with lock at once

  // Release only after a full hold of lock
  a_rst_hold: assert property (
    @(posedge sys_clk_in) disable iff (rst)
    $fell(power_on_rst) |-> $past(locked, RST_HOLD)
  ) else $error("power-on reset released before the hold time");

endmodule

/* hdl/delay_ctrl_ready.sv */
`timescale 1ns/1ns

module delay_ctrl_ready import infra_pkg::*; #(
  parameter int READY_CYCLES = 32
) (
  input  logic sys_clk_in,
  input  logic rst,
  input  logic ctrl_rst,
  output logic ready
);

  localparam logic [CNT_W-1:0] READY_LAST = CNT_W'(READY_CYCLES - 1);

  // Stands in for the delay line calibration time
  logic [CNT_W-1:0] cal_cnt;

  always_ff @(posedge sys_clk_in) begin
    if (rst || ctrl_rst) begin
      cal_cnt <= '0;
      ready   <= 1'b0;
    end else if (!ready) begin
      if (cal_cnt == READY_LAST) begin
        ready <= 1'b1;  // Sticky until next controller reset
      end else begin
        cal_cnt <= cal_cnt + 1'b1;
      end
    end
  end

endmodule

/* hdl/board_infrastructure.sv */
`timescale 1ns/1ns

module board_infrastructure import infra_pkg::*; #(
  parameter int SYS_DIVIDE   = DEF_SYS_DIVIDE,
  parameter int AUX_DIVIDE   = DEF_AUX_DIVIDE,
  parameter int LOCK_WINDOWS = 3,
  parameter int RST_HOLD     = 16,
  parameter int READY_CYCLES = 32,
  parameter int IDCTRL_100   = 1
) (
  input  logic sys_clk_in,
  input  logic rst,
  input  logic aux_ref_present,
  input  logic idelay_rst,
  output logic sys_clk,
  output logic sys_clk90,
  output logic sys_clk180,
  output logic sys_clk270,
  output logic sys_clk2x,
  output logic sys_clk_lock,
  output logic aux_clk,
  output logic aux_clk90,
  output logic aux_clk180,
  output logic aux_clk270,
  output logic aux_clk2x,
  output logic aux_clk_lock,
  output logic op_power_on_rst,
  output logic idelay_rdy,
  output logic idelay100_rdy
);

  // System reference always present on the board
  clk_mgr #(
    .DIVIDE       (SYS_DIVIDE),
    .LOCK_WINDOWS (LOCK_WINDOWS)
  ) sys_mgr (
    .sys_clk_in  (sys_clk_in),
    .rst         (rst),
    .ref_present (1'b1),
    .clk_out     (sys_clk),
    .clk90       (sys_clk90),
    .clk180      (sys_clk180),
    .clk270      (sys_clk270),
    .clk2x       (sys_clk2x),
    .locked      (sys_clk_lock)
  );

  clk_mgr #(
    .DIVIDE       (AUX_DIVIDE),
    .LOCK_WINDOWS (LOCK_WINDOWS)
  ) aux_mgr (
    .sys_clk_in  (sys_clk_in),
    .rst         (rst),
    .ref_present (aux_ref_present),
    .clk_out     (aux_clk),
    .clk90       (aux_clk90),
    .clk180      (aux_clk180),
    .clk270      (aux_clk270),
    .clk2x       (aux_clk2x),
    .locked      (aux_clk_lock)
  );

  // Power-on reset follows system lock only
  reset_sequencer #(
    .RST_HOLD (RST_HOLD)
  ) por_seq (
    .sys_clk_in   (sys_clk_in),
    .rst          (rst),
    .locked       (sys_clk_lock),
    .power_on_rst (op_power_on_rst)
  );

  if (IDCTRL_100 != 0) begin : gen_dual_idelayctrl
    delay_ctrl_ready #(
      .READY_CYCLES (READY_CYCLES)
    ) idelayctrl100_inst (
      .sys_clk_in (sys_clk_in),
      .rst        (rst),
      .ctrl_rst   (idelay_rst),
      .ready      (idelay100_rdy)
    );

    delay_ctrl_ready #(
      .READY_CYCLES (READY_CYCLES)
    ) idelayctrl200_inst (
      .sys_clk_in (sys_clk_in),
      .rst        (rst),
      .ctrl_rst   (idelay_rst),
      .ready      (idelay_rdy)
    );
  end else begin : gen_single_idelayctrl
    delay_ctrl_ready #(
      .READY_CYCLES (READY_CYCLES)
    ) idelayctrl_inst (
      .sys_clk_in (sys_clk_in),
      .rst        (rst),
      .ctrl_rst   (idelay_rst),
      .ready      (idelay_rdy)
    );

    assign idelay100_rdy = 1'b0;  // No 100 MHz controller fitted
  end

endmodule

/* bench/board_infrastructure_tb.sv */
`timescale 1ns/1ns

module board_infrastructure_tb import infra_pkg::*; ();

  localparam int SYS_DIV      = DEF_SYS_DIVIDE;
  localparam int AUX_DIV      = DEF_AUX_DIVIDE;
  localparam int LOCK_WINDOWS = 3;
  localparam int RST_HOLD     = 16;
  localparam int READY_CYCLES = 32;
  localparam int SYS_WIN      = EDGES_PER_WINDOW * SYS_DIV;  // Lock window lengths
  localparam int AUX_WIN      = EDGES_PER_WINDOW * AUX_DIV;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_ROWS     = 6;

  // Error classes
  localparam int K_PHASE = 0;
  localparam int K_LOCK  = 1;
  localparam int K_RST   = 2;
  localparam int K_RDY   = 3;
  localparam int K_TABLE = 4;

  typedef struct packed {
    logic aux_ref;
    logic idl_rst;
    int   cycles;
    logic sys_lock;  // Expected at the end of the row
    logic aux_lock;
    logic por;
    logic rdy;
  } row_t;

  logic sys_clk_in;
  logic rst;
  logic aux_ref_present;
  logic idelay_rst;
  logic sys_clk;
  logic sys_clk90;
  logic sys_clk180;
  logic sys_clk270;
  logic sys_clk2x;
  logic sys_clk_lock;
  logic aux_clk;
  logic aux_clk90;
  logic aux_clk180;
  logic aux_clk270;
  logic aux_clk2x;
  logic aux_clk_lock;
  logic op_power_on_rst;
  logic idelay_rdy;
  logic idelay100_rdy;

  row_t       rows [NUM_ROWS];
  int         err_cnt [5];
  int         cycle_cnt = 0;
  int         cycle_limit = 0;
  int         sys_cnt;     // Model division counters
  int         aux_cnt;
  logic [4:0] exp_sys;     // {clk2x, clk270, clk180, clk90, clk}
  logic [4:0] exp_aux;
  int         sys_run;     // Cycles since rst fell
  int         aux_on;      // Cycles with the aux reference present
  int         aux_off;
  logic       aux_from_reset;
  int         lock_run;    // Consecutive cycles of sys lock seen
  int         rdy_cnt;     // Cycles since idelay_rst fell

  board_infrastructure uut (
    .sys_clk_in      (sys_clk_in),
    .rst             (rst),
    .aux_ref_present (aux_ref_present),
    .idelay_rst      (idelay_rst),
    .sys_clk         (sys_clk),
    .sys_clk90       (sys_clk90),
    .sys_clk180      (sys_clk180),
    .sys_clk270      (sys_clk270),
    .sys_clk2x       (sys_clk2x),
    .sys_clk_lock    (sys_clk_lock),
    .aux_clk         (aux_clk),
    .aux_clk90       (aux_clk90),
    .aux_clk180      (aux_clk180),
    .aux_clk270      (aux_clk270),
    .aux_clk2x       (aux_clk2x),
    .aux_clk_lock    (aux_clk_lock),
    .op_power_on_rst (op_power_on_rst),
    .idelay_rdy      (idelay_rdy),
    .idelay100_rdy   (idelay100_rdy)
  );

  always #20 sys_clk_in = ~sys_clk_in;

  always @(posedge sys_clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run went past its limit of %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // Expected outputs of one manager for the counter value before the edge
  function automatic logic [4:0] mgr_outputs(input int c, input int d);
    logic [4:0] v;
    int         k;
    int         shifted;
    for (k = 0; k < 4; k++) begin
      shifted = c - k * (d / 4);  // Phase k lags the base by k quarters
      if (shifted < 0) begin
        shifted = shifted + d;
      end
      v[k] = (shifted < d / 2);
    end
    v[4] = ((c % (d / 2)) < d / 4);
    return v;
  endfunction

  function automatic string phase_name(input string prefix, input int idx);
    case (idx)
      0: return {prefix, "clk"};
      1: return {prefix, "clk90"};
      2: return {prefix, "clk180"};
      3: return {prefix, "clk270"};
      default: return {prefix, "clk2x"};
    endcase
  endfunction

  task automatic check_value(input string name, input logic got, input logic exp,
                             input int kind);
    if (got !== exp) begin
      err_cnt[kind] = err_cnt[kind] + 1;
      $display("** Error: %s got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
    end
  endtask

  task automatic report_fault(input string msg, input int kind);
    err_cnt[kind] = err_cnt[kind] + 1;
    $display("Error at cycle %0d: %s", cycle_cnt, msg);
  endtask

  // Columns: aux_ref, idelay_rst, cycles, sys_lock, aux_lock, power_on_rst, idelay_rdy
  task automatic load_rows();
    rows[0] = '{1'b1, 1'b1, 10, 1'b0, 1'b0, 1'b1, 1'b0};   // Controllers held in reset
    rows[1] = '{1'b1, 1'b0, 60, 1'b0, 1'b0, 1'b1, 1'b1};   // Ready after calibration
    rows[2] = '{1'b1, 1'b0, 130, 1'b1, 1'b1, 1'b0, 1'b1};  // Both locked, reset released
    rows[3] = '{1'b0, 1'b0, 120, 1'b1, 1'b0, 1'b0, 1'b1};  // Aux reference lost
    rows[4] = '{1'b1, 1'b1, 4, 1'b1, 1'b0, 1'b0, 1'b0};    // Restore, pulse controller reset
    rows[5] = '{1'b1, 1'b0, 240, 1'b1, 1'b1, 1'b0, 1'b1};  // Aux relocks
  endtask

  // One clock edge, model step and checks; returns at the drive point
  task automatic step_cycle();
    logic [4:0] got_sys;
    logic [4:0] got_aux;
    logic       exp_por;
    int         k;
    @(posedge sys_clk_in);
    #1;
    if (rst) begin
      sys_cnt        = 0;
      aux_cnt        = 0;
      exp_sys        = '0;
      exp_aux        = '0;
      sys_run        = 0;
      aux_on         = 0;
      aux_off        = 0;
      aux_from_reset = 1'b1;
      rdy_cnt        = 0;
    end else begin
      exp_sys = mgr_outputs(sys_cnt, SYS_DIV);
      sys_cnt = (sys_cnt + 1) % SYS_DIV;
      sys_run++;
      if (aux_ref_present) begin
        exp_aux = mgr_outputs(aux_cnt, AUX_DIV);
        aux_cnt = (aux_cnt + 1) % AUX_DIV;
        aux_on++;
        aux_off = 0;
      end else begin
        exp_aux        = '0;  // Counter frozen, outputs parked
        aux_on         = 0;
        aux_off++;
        aux_from_reset = 1'b0;
      end
      if (idelay_rst) begin
        rdy_cnt = 0;
      end else begin
        rdy_cnt++;
      end
    end
    if (sys_clk_lock) begin
      lock_run++;
    end else begin
      lock_run = 0;
    end
    got_sys = {sys_clk2x, sys_clk270, sys_clk180, sys_clk90, sys_clk};
    got_aux = {aux_clk2x, aux_clk270, aux_clk180, aux_clk90, aux_clk};
    for (k = 0; k < 5; k++) begin
      check_value(phase_name("sys_", k), got_sys[k], exp_sys[k], K_PHASE);
      check_value(phase_name("aux_", k), got_aux[k], exp_aux[k], K_PHASE);
    end
    if (sys_clk_lock && (sys_run < LOCK_WINDOWS * SYS_WIN)) begin
      report_fault("sys_clk_lock rose before its lock windows passed", K_LOCK);
    end
    if (!sys_clk_lock && (sys_run >= (LOCK_WINDOWS + 1) * SYS_WIN)) begin
      report_fault("sys_clk_lock low after its lock deadline", K_LOCK);
    end
    if (aux_clk_lock && aux_from_reset && (aux_on < LOCK_WINDOWS * AUX_WIN)) begin
      report_fault("aux_clk_lock rose before its lock windows passed", K_LOCK);
    end
    if (!aux_clk_lock && (aux_on >= (LOCK_WINDOWS + 1) * AUX_WIN)) begin
      report_fault("aux_clk_lock low after its lock deadline", K_LOCK);
    end
    // Window in progress at the loss may still close good
    if (aux_clk_lock && (aux_off >= 2 * AUX_WIN)) begin
      report_fault("aux_clk_lock still high after the aux reference was lost", K_LOCK);
    end
    exp_por = !(sys_clk_lock && (lock_run - 1 >= RST_HOLD));
    check_value("op_power_on_rst", op_power_on_rst, exp_por, K_RST);
    check_value("idelay_rdy", idelay_rdy, (rdy_cnt >= READY_CYCLES), K_RDY);
    check_value("idelay100_rdy", idelay100_rdy, (rdy_cnt >= READY_CYCLES), K_RDY);
    #1;
  endtask

  initial begin
    int i;
    int total;
    sys_clk_in      = 1'b0;
    rst             = 1'b1;
    aux_ref_present = 1'b1;
    idelay_rst      = 1'b1;
    load_rows();
    cycle_limit = RESET_CYCLES + 200;
    for (i = 0; i < NUM_ROWS; i++) begin
      cycle_limit = cycle_limit + rows[i].cycles;
    end
    repeat (RESET_CYCLES) step_cycle();
    rst = 1'b0;
    for (i = 0; i < NUM_ROWS; i++) begin
      aux_ref_present = rows[i].aux_ref;
      idelay_rst      = rows[i].idl_rst;
      repeat (rows[i].cycles) step_cycle();
      check_value("sys_clk_lock", sys_clk_lock, rows[i].sys_lock, K_TABLE);
      check_value("aux_clk_lock", aux_clk_lock, rows[i].aux_lock, K_TABLE);
      check_value("op_power_on_rst", op_power_on_rst, rows[i].por, K_TABLE);
      check_value("idelay_rdy", idelay_rdy, rows[i].rdy, K_TABLE);
    end
    total = err_cnt[K_PHASE] + err_cnt[K_LOCK] + err_cnt[K_RST] + err_cnt[K_RDY] +
            err_cnt[K_TABLE];
    $display("Errors: phase %0d, lock %0d, reset %0d, ready %0d, table %0d, total %0d",
             err_cnt[K_PHASE], err_cnt[K_LOCK], err_cnt[K_RST], err_cnt[K_RDY],
             err_cnt[K_TABLE], total);
    if (total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
hdl/infra_pkg.sv
hdl/clk_phase_gen.sv
hdl/lock_detect.sv
hdl/clk_mgr.sv
hdl/reset_sequencer.sv
hdl/delay_ctrl_ready.sv
hdl/board_infrastructure.sv
bench/board_infrastructure_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the board infrastructure testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module board_infrastructure_tb -o board_infrastructure_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/board_infrastructure_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
